/* design/reward_config.svh */
/*
 * Reward subsystem configuration.
 * Field geometry, effect durations in game ticks, the LFSR start value
 * and the overlay colours as 12-bit RGB.
 */
`ifndef REWARD_CONFIG_SVH
`define REWARD_CONFIG_SVH

// ==================== field
`define REWARD_GRID_W        40
`define REWARD_GRID_H        30
`define REWARD_CELL_SHIFT    4      // one cell is 16 pixels.

// ==================== effects
`define REWARD_SHIELD_TICKS  30
`define REWARD_SLOW_TICKS    30
`define REWARD_RECOVER_TICKS 10
`define REWARD_GRADE_TICKS   6

// ==================== random and display
`define REWARD_LFSR_SEED     16'hACE1
`define REWARD_BAR_ROWS      8
`define REWARD_COLOR_SHIELD  12'h0FF
`define REWARD_COLOR_SLOW    12'h00F
`define REWARD_COLOR_GRADE   12'hFF0
`define REWARD_COLOR_BAR     12'h0F0

`endif

/* design/reward_pkg.sv */
/*
 * Reward subsystem types.
 * Game phase, reward kind and effect state encodings, and the packed
 * structs passed between the spawner, the effect machine and the overlay.
 */
`default_nettype none

package reward_pkg;

	typedef enum logic [1:0] {
		GAME_IDLE = 2'b00,
		GAME_OVER = 2'b01,
		GAME_RUN  = 2'b10
	} game_state_e;

	typedef enum logic [1:0] {
		KIND_NONE   = 2'd0,
		KIND_SHIELD = 2'd1,
		KIND_SLOW   = 2'd2,
		KIND_GRADE  = 2'd3
	} reward_kind_e;

	typedef enum logic [2:0] {
		EFF_IDLE,
		EFF_SHIELD,
		EFF_SLOW,
		EFF_RECOVER,   // speed climbs back after the slow-down.
		EFF_GRADE
	} effect_state_e;

	typedef struct packed {
		logic [5:0] x;
		logic [5:0] y;
	} cell_t;

	typedef struct packed {
		logic         valid;
		reward_kind_e kind;
		cell_t        pos;
	} reward_t;

	typedef struct packed {
		logic [10:0] x;
		logic [10:0] y;
	} pixel_t;

	typedef struct packed {
		logic       shield;
		logic       slow;
		logic       grade;
		logic       speed_recover;
		logic [5:0] remaining;
	} effect_t;

endpackage

`default_nettype wire

/* design/reward_spawner.sv */
/*
 * Reward spawner.
 * A free-running 16-bit LFSR supplies the cell and kind of the next reward.
 * A reward is placed on a game tick while none is on the field, and it
 * stays there until the effect machine reports it eaten.
 */
`timescale 1ns/1ps
`default_nettype none
`include "reward_config.svh"

module reward_spawner
	import reward_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  game_state_e game,
	input  logic        tick,
	input  logic        eaten,
	output reward_t     reward
);

	logic [15:0]  lfsr;
	cell_t        cand_pos;
	reward_kind_e cand_kind;

	// folds a raw 6-bit value into 0..limit-1.
	// three passes cover every limit of 16 or more.
	function automatic logic [5:0] fold(input logic [5:0] value, input logic [5:0] limit);
		logic [5:0] v;
		v = value;
		for (int i = 0; i < 3; i++)
		begin
			if (v >= limit)
				v = v - limit;
		end
		return v;
	endfunction

	// ==================== random source
	// taps 16, 14, 13 and 11 give the maximal period.
	always_ff @(posedge clk)
	begin
		if (rst || game != GAME_RUN)
			lfsr <= `REWARD_LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	always_comb
	begin
		cand_pos.x = fold(lfsr[5:0], 6'(`REWARD_GRID_W));
		cand_pos.y = fold(lfsr[11:6], 6'(`REWARD_GRID_H));
		if (lfsr[13:12] == 2'd0)
			cand_kind = KIND_SHIELD;   // no empty rewards on the field.
		else
			cand_kind = reward_kind_e'(lfsr[13:12]);
	end

	// ==================== placed reward
	// eaten wins over tick, so a fresh reward waits for a later tick.
	always_ff @(posedge clk)
	begin
		if (rst || game != GAME_RUN)
			reward <= '0;
		else if (eaten)
			reward.valid <= 1'b0;
		else if (tick && !reward.valid)
		begin
			reward.valid <= 1'b1;
			reward.kind  <= cand_kind;
			reward.pos   <= cand_pos;
		end
	end

	// ==================== checks
	a_pos_in_field: assert property (@(posedge clk) disable iff (rst)
		reward.valid |-> (reward.pos.x < 6'(`REWARD_GRID_W)
			&& reward.pos.y < 6'(`REWARD_GRID_H)));

	a_spawn_on_tick: assert property (@(posedge clk) disable iff (rst)
		$rose(reward.valid) |-> $past(tick));

endmodule

`default_nettype wire

/* design/reward_effects.sv */
/*
 * Reward effect machine.
 * Detects the snake head on the reward, applies the cheat switches and
 * times the active effect in game ticks. The slow-down ends in a short
 * speed-recover phase. The LEDs show which phase is running.
 */
`timescale 1ns/1ps
`default_nettype none
`include "reward_config.svh"

module reward_effects
	import reward_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  game_state_e game,
	input  logic        tick,
	input  cell_t       head,
	input  logic [2:0]  cheat,
	input  reward_t     reward,
	output logic        eaten,
	output effect_t     effect,
	output logic [15:0] led
);

	effect_state_e state;
	effect_state_e cheat_state;
	effect_state_e kind_state;
	logic [5:0]    remaining;
	logic          cheat_on;
	logic          eat_hit;

	function automatic logic [5:0] duration(input effect_state_e s);
		case (s)
			EFF_SHIELD:  return 6'(`REWARD_SHIELD_TICKS);
			EFF_SLOW:    return 6'(`REWARD_SLOW_TICKS);
			EFF_RECOVER: return 6'(`REWARD_RECOVER_TICKS);
			EFF_GRADE:   return 6'(`REWARD_GRADE_TICKS);
			default:     return 6'd0;
		endcase
	endfunction

	// ==================== start requests
	always_comb
	begin
		case (cheat)
			3'b001:  cheat_state = EFF_SHIELD;
			3'b010:  cheat_state = EFF_SLOW;
			3'b100:  cheat_state = EFF_GRADE;
			default: cheat_state = EFF_IDLE;   // off, or more than one switch.
		endcase
		case (reward.kind)
			KIND_SHIELD: kind_state = EFF_SHIELD;
			KIND_SLOW:   kind_state = EFF_SLOW;
			KIND_GRADE:  kind_state = EFF_GRADE;
			default:     kind_state = EFF_IDLE;
		endcase
	end

	assign cheat_on = cheat_state != EFF_IDLE;
	// the reward is still valid on the eaten clock, so that clock is masked.
	assign eat_hit = reward.valid && !eaten && head == reward.pos && !cheat_on;

	// ==================== state and timer
	always_ff @(posedge clk)
	begin
		if (rst || game != GAME_RUN)
		begin
			state     <= EFF_IDLE;
			remaining <= '0;
			eaten     <= 1'b0;
		end
		else
		begin
			eaten <= eat_hit;
			if (cheat_on)
			begin
				state     <= cheat_state;
				remaining <= duration(cheat_state);
			end
			else if (eat_hit)
			begin
				state     <= kind_state;
				remaining <= duration(kind_state);
			end
			else if (tick && state != EFF_IDLE)
			begin
				if (remaining == 6'd1)
				begin
					if (state == EFF_SLOW)
					begin
						state     <= EFF_RECOVER;
						remaining <= duration(EFF_RECOVER);
					end
					else
					begin
						state     <= EFF_IDLE;
						remaining <= '0;
					end
				end
				else
					remaining <= remaining - 6'd1;
			end
		end
	end

	always_comb
	begin
		effect.shield        = state == EFF_SHIELD;
		effect.slow          = state == EFF_SLOW;
		effect.grade         = state == EFF_GRADE;
		effect.speed_recover = state == EFF_RECOVER;
		effect.remaining     = remaining;
		case (state)
			EFF_SHIELD:  led = 16'h000F;
			EFF_SLOW:    led = 16'h00F0;
			EFF_GRADE:   led = 16'h0F00;
			EFF_RECOVER: led = 16'hF000;
			default:     led = 16'h0000;
		endcase
		if (eaten)
			led = 16'hFFFF;   // flash on the clock the reward is taken.
	end

	// ==================== checks
	a_one_effect: assert property (@(posedge clk) disable iff (rst)
		$onehot0({effect.shield, effect.slow, effect.grade, effect.speed_recover}));

	a_eaten_strobe: assert property (@(posedge clk) disable iff (rst)
		eaten |=> !eaten);

endmodule

`default_nettype wire

/* design/reward_overlay.sv */
/*
 * Reward overlay.
 * Gives the colour of the current VGA pixel: the reward icon in its grid
 * cell, and a bar along the top rows that shrinks with the ticks left on
 * the active effect. The colour is registered.
 */
`timescale 1ns/1ps
`default_nettype none
`include "reward_config.svh"

module reward_overlay
	import reward_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  game_state_e game,
	input  pixel_t      pixel,
	input  reward_t     reward,
	input  effect_t     effect,
	output logic [11:0] rgb
);

	logic [10:0] cell_x;
	logic [10:0] cell_y;
	logic [10:0] bar_len;
	logic        icon_hit;
	logic        bar_hit;
	logic [11:0] icon_rgb;
	logic [11:0] bar_rgb;

	// ==================== icon
	assign cell_x   = pixel.x >> `REWARD_CELL_SHIFT;
	assign cell_y   = pixel.y >> `REWARD_CELL_SHIFT;
	assign icon_hit = reward.valid && cell_x == {5'd0, reward.pos.x}
		&& cell_y == {5'd0, reward.pos.y};

	always_comb
	begin
		icon_rgb = 12'h000;
		if (icon_hit)
		begin
			case (reward.kind)
				KIND_SHIELD: icon_rgb = `REWARD_COLOR_SHIELD;
				KIND_SLOW:   icon_rgb = `REWARD_COLOR_SLOW;
				KIND_GRADE:  icon_rgb = `REWARD_COLOR_GRADE;
				default:     icon_rgb = 12'h000;
			endcase
		end
	end

	// ==================== time bar
	assign bar_len = {2'd0, effect.remaining, 3'd0};   // eight pixels per tick.
	assign bar_hit = pixel.y < 11'(`REWARD_BAR_ROWS) && pixel.x < bar_len;
	assign bar_rgb = bar_hit ? `REWARD_COLOR_BAR : 12'h000;

	always_ff @(posedge clk)
	begin
		if (rst || game != GAME_RUN)
			rgb <= '0;
		else
			rgb <= icon_rgb | bar_rgb;
	end

endmodule

`default_nettype wire

/* design/reward_logic.sv */
/*
 * Reward subsystem top level.
 * Connects the spawner, the effect machine and the pixel overlay. The
 * eaten strobe runs from the effect machine back to the spawner.
 */
`timescale 1ns/1ps
`default_nettype none

module reward_logic
	import reward_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  game_state_e game,
	input  logic        tick,
	input  cell_t       head,
	input  logic [2:0]  cheat,
	input  pixel_t      pixel,
	output reward_t     reward,
	output effect_t     effect,
	output logic [15:0] led,
	output logic [11:0] rgb
);

	logic eaten;   // one clock per reward taken.

	reward_spawner u_spawner (
		.clk    (clk),
		.rst    (rst),
		.game   (game),
		.tick   (tick),
		.eaten  (eaten),
		.reward (reward)
	);

	reward_effects u_effects (
		.clk    (clk),
		.rst    (rst),
		.game   (game),
		.tick   (tick),
		.head   (head),
		.cheat  (cheat),
		.reward (reward),
		.eaten  (eaten),
		.effect (effect),
		.led    (led)
	);

	reward_overlay u_overlay (
		.clk    (clk),
		.rst    (rst),
		.game   (game),
		.pixel  (pixel),
		.reward (reward),
		.effect (effect),
		.rgb    (rgb)
	);

endmodule

`default_nettype wire

/* tb/reward_logic_tb.sv */
/*
 * Testbench for the reward subsystem.
 * Reads commands from the tests file, drives the DUT and keeps a small
 * reference model of the placed reward and the running effect.
 */
`timescale 1ns/1ps
`default_nettype none
`include "reward_config.svh"

module reward_logic_tb
	import reward_pkg::*;
();

	logic        clk = 1'b0;
	logic        rst;
	game_state_e game;
	logic        tick;
	cell_t       head;
	logic [2:0]  cheat;
	pixel_t      pixel;
	reward_t     reward;
	effect_t     effect;
	logic [15:0] led;
	logic [11:0] rgb;

	// ==================== reference model
	reward_t       exp_reward;
	effect_state_e exp_state;
	logic [5:0]    exp_rem;

	localparam cell_t off_field = '{x: 6'd63, y: 6'd63};   // never inside the field.

	reward_logic DUT (
		.clk    (clk),
		.rst    (rst),
		.game   (game),
		.tick   (tick),
		.head   (head),
		.cheat  (cheat),
		.pixel  (pixel),
		.reward (reward),
		.effect (effect),
		.led    (led),
		.rgb    (rgb)
	);

	always #5 clk = ~clk;

	task automatic step_clock();
		@(posedge clk);
		#1;   // inputs change and outputs are read here.
	endtask

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_reward(input reward_t got, input reward_t want);
		if (got !== want)
			stop_with_error($sformatf("CHECK FAILED at %0t: reward got %h expected %h",
				$time, got, want));
	endtask

	task automatic check_effect(input effect_t got, input effect_t want);
		if (got !== want)
			stop_with_error($sformatf("CHECK FAILED at %0t: effect got %h expected %h",
				$time, got, want));
	endtask

	task automatic check_level(input string name, input logic [15:0] got,
		input logic [15:0] want);
		if (got !== want)
			stop_with_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, name, got, want));
	endtask

	function automatic logic [5:0] duration_of(input effect_state_e s);
		case (s)
			EFF_SHIELD:  return 6'(`REWARD_SHIELD_TICKS);
			EFF_SLOW:    return 6'(`REWARD_SLOW_TICKS);
			EFF_RECOVER: return 6'(`REWARD_RECOVER_TICKS);
			EFF_GRADE:   return 6'(`REWARD_GRADE_TICKS);
			default:     return 6'd0;
		endcase
	endfunction

	function automatic logic [15:0] led_for(input effect_state_e s);
		case (s)
			EFF_SHIELD:  return 16'h000F;
			EFF_SLOW:    return 16'h00F0;
			EFF_GRADE:   return 16'h0F00;
			EFF_RECOVER: return 16'hF000;
			default:     return 16'h0000;
		endcase
	endfunction

	task automatic start_effect(input effect_state_e s);
		exp_state = s;
		exp_rem   = duration_of(s);
	endtask

	// compares reward, effect and led with the model; flash is the eaten clock.
	task automatic verify_outputs(input logic flash);
		effect_t want;
		want.shield        = exp_state == EFF_SHIELD;
		want.slow          = exp_state == EFF_SLOW;
		want.grade         = exp_state == EFF_GRADE;
		want.speed_recover = exp_state == EFF_RECOVER;
		want.remaining     = exp_rem;
		check_reward(reward, exp_reward);
		check_effect(effect, want);
		check_level("led", led, flash ? 16'hFFFF : led_for(exp_state));
	endtask

	// ==================== commands
	task automatic set_game(input string name);
		if (name == "run")
			game = GAME_RUN;
		else if (name == "over")
			game = GAME_OVER;
		else if (name == "idle")
			game = GAME_IDLE;
		else
			stop_with_error($sformatf("unknown game phase %s in the tests file", name));
		if (game != GAME_RUN)
			pixel = '0;   // bar origin, lit while an effect runs.
		step_clock();
		if (game != GAME_RUN)
		begin
			exp_reward = '0;
			start_effect(EFF_IDLE);
			check_level("rgb", {4'd0, rgb}, 16'd0);
		end
		verify_outputs(1'b0);
	endtask

	task automatic send_ticks(input int count);
		int gap;
		for (int i = 0; i < count; i++)
		begin
			gap = int'($urandom % 4);
			repeat (gap) step_clock();
			tick = 1'b1;
			step_clock();
			tick = 1'b0;
			if (game == GAME_RUN && exp_state != EFF_IDLE)
			begin
				if (exp_rem != 6'd1)
					exp_rem = exp_rem - 6'd1;
				else if (exp_state == EFF_SLOW)
					start_effect(EFF_RECOVER);
				else
					start_effect(EFF_IDLE);
			end
			if (game == GAME_RUN && !exp_reward.valid)
			begin
				check_level("reward.valid", {15'd0, reward.valid}, 16'd1);
				if (reward.pos.x >= 6'(`REWARD_GRID_W) || reward.pos.y >= 6'(`REWARD_GRID_H))
					stop_with_error("a new reward was placed outside the field");
				if (reward.kind == KIND_NONE)
					stop_with_error("a new reward was placed without a kind");
				exp_reward = reward;   // cell and kind come from the LFSR.
			end
			verify_outputs(1'b0);
		end
	endtask

	task automatic eat_reward();
		int waited;
		waited = 0;
		while (!reward.valid)
		begin
			if (waited >= 200)
				stop_with_error("timed out after 200 clocks waiting for a reward to eat");
			step_clock();
			waited++;
		end
		check_reward(reward, exp_reward);
		head = exp_reward.pos;
		step_clock();
		case (exp_reward.kind)
			KIND_SHIELD: start_effect(EFF_SHIELD);
			KIND_SLOW:   start_effect(EFF_SLOW);
			KIND_GRADE:  start_effect(EFF_GRADE);
			default:     stop_with_error("the eaten reward has no kind");
		endcase
		verify_outputs(1'b1);
		step_clock();
		head = off_field;
		exp_reward.valid = 1'b0;
		verify_outputs(1'b0);
	endtask

	task automatic apply_cheat(input logic [2:0] value);
		cheat = value;
		step_clock();
		cheat = 3'b000;
		case (value)
			3'b001:  start_effect(EFF_SHIELD);
			3'b010:  start_effect(EFF_SLOW);
			3'b100:  start_effect(EFF_GRADE);
			default: ;   // off or more than one switch has no effect.
		endcase
		verify_outputs(1'b0);
	endtask

	task automatic probe_pixel(input string where, input int px, input int py,
		input string colour);
		logic [11:0] want;
		if (where == "cell")
		begin
			if (!exp_reward.valid)
				stop_with_error("a pixel step asked for the reward cell but none is placed");
			pixel.x = (11'(exp_reward.pos.x) << `REWARD_CELL_SHIFT) + 11'(px);
			pixel.y = (11'(exp_reward.pos.y) << `REWARD_CELL_SHIFT) + 11'(py);
		end
		else
		begin
			pixel.x = 11'(px);
			pixel.y = 11'(py);
		end
		step_clock();
		want = 12'h000;
		if (colour != "kind")
			void'($sscanf(colour, "%h", want));
		else if (exp_reward.kind == KIND_SHIELD)
			want = `REWARD_COLOR_SHIELD;
		else if (exp_reward.kind == KIND_SLOW)
			want = `REWARD_COLOR_SLOW;
		else if (exp_reward.kind == KIND_GRADE)
			want = `REWARD_COLOR_GRADE;
		check_level("rgb", {4'd0, rgb}, {4'd0, want});
	endtask

	// ==================== main sequence
	initial
	begin
		int fd;
		int a;
		int b;
		int c;
		string cmd;
		string tok;
		string tok2;
		logic [1023:0] line;
		void'($urandom(52));
		rst   = 1'b1;
		game  = GAME_IDLE;
		tick  = 1'b0;
		head  = off_field;
		cheat = 3'b000;
		pixel = '0;
		exp_reward = '0;
		start_effect(EFF_IDLE);
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		step_clock();
		verify_outputs(1'b0);
		check_level("rgb", {4'd0, rgb}, 16'd0);
		fd = $fopen("tb/reward_tests.txt", "r");
		if (fd == 0)
			stop_with_error("cannot open tb/reward_tests.txt");
		while ($fscanf(fd, "%s", cmd) == 1)
		begin
			if (cmd.getc(0) == "#")
				void'($fgets(line, fd));
			else if (cmd == "game" && $fscanf(fd, "%s", tok) == 1)
				set_game(tok);
			else if (cmd == "tick" && $fscanf(fd, "%d", a) == 1)
				send_ticks(a);
			else if (cmd == "eat")
				eat_reward();
			else if (cmd == "cheat" && $fscanf(fd, "%h", a) == 1)
				apply_cheat(3'(a));
			else if (cmd == "pixel" && $fscanf(fd, "%s %d %d %s", tok, a, b, tok2) == 4)
				probe_pixel(tok, a, b, tok2);
			else if (cmd == "check" && $fscanf(fd, "%d %h %d", a, b, c) == 3)
			begin
				check_level("reward.valid", {15'd0, reward.valid}, 16'(a));
				check_level("led", led, 16'(b));
				check_level("effect.remaining", {10'd0, effect.remaining}, 16'(c));
				verify_outputs(1'b0);
			end
			else
				stop_with_error($sformatf("bad line for command %s in the tests file", cmd));
		end
		$fclose(fd);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/reward_pkg.sv
design/reward_spawner.sv
design/reward_effects.sv
design/reward_overlay.sv
design/reward_logic.sv
tb/reward_logic_tb.sv

/* run.sh */
#!/bin/sh
# Builds the reward subsystem testbench with Verilator and runs it.
# The script exits with the status of the step that went wrong.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module reward_logic_tb \
	-o reward_logic_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/reward_logic_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation ended with status $status"
	exit "$status"
fi

exit 0

/* tb/reward_tests.txt */
# columns: command, operands, expected values
# game <idle|run|over>, tick <count>, eat, cheat <hex>, pixel <cell|abs> <x> <y> <rgb|kind>, check <valid> <led> <remaining>
check 0 0000 0
tick 3
check 0 0000 0
pixel abs 0 0 000
game run
tick 1
check 1 0000 0
pixel cell 8 8 kind
eat
tick 2
pixel cell 4 12 kind
cheat 1
check 1 000f 30
tick 29
check 1 000f 1
tick 1
check 1 0000 0
cheat 4
tick 6
check 1 0000 0
cheat 2
tick 30
check 1 f000 10
tick 10
check 1 0000 0
cheat 1
cheat 3
check 1 000f 30
cheat 2
check 1 00f0 30
eat
cheat 7
cheat 4
check 0 0f00 6
pixel abs 47 0 0f0
pixel abs 48 0 000
pixel abs 0 7 0f0
pixel abs 0 8 000
pixel abs 300 200 000
tick 1
check 1 0f00 5
game over
check 0 0000 0
pixel abs 0 0 000
tick 2
check 0 0000 0
